// ==== verilog/exe_pkg.sv ====
package exe_pkg;

	// widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int ALU_FN_W   = 3;
	localparam int WB_SEL_W   = 2;
	localparam int MODE_W     = 2;
	localparam int EXC_W      = 4;

	// exception flag positions inside exc
	localparam int EXC_MISALIGNED = 3;
	localparam int EXC_ILLEGAL    = 2;
	localparam int EXC_ECALL      = 1;
	localparam int EXC_EBREAK     = 0;

	localparam logic [ALU_FN_W-1:0] ALU_ADD = 3'd0;
	localparam logic [ALU_FN_W-1:0] ALU_SUB = 3'd1;
	localparam logic [ALU_FN_W-1:0] ALU_AND = 3'd2;
	localparam logic [ALU_FN_W-1:0] ALU_OR  = 3'd3;
	localparam logic [ALU_FN_W-1:0] ALU_XOR = 3'd4;
	localparam logic [ALU_FN_W-1:0] ALU_SLL = 3'd5;
	localparam logic [ALU_FN_W-1:0] ALU_SRL = 3'd6;
	localparam logic [ALU_FN_W-1:0] ALU_SLT = 3'd7; // signed compare

	localparam logic [WB_SEL_W-1:0] WB_ALU   = 2'd0;
	localparam logic [WB_SEL_W-1:0] WB_PC4   = 2'd1;
	localparam logic [WB_SEL_W-1:0] WB_LUI   = 2'd2;
	localparam logic [WB_SEL_W-1:0] WB_AUIPC = 2'd3;

	localparam logic [MODE_W-1:0] MODE_U = 2'd0;
	localparam logic [MODE_W-1:0] MODE_S = 2'd1;
	localparam logic [MODE_W-1:0] MODE_M = 2'd3;

	// synchronous causes
	localparam logic [XLEN-2:0] C_I_MISALIGNED = 31'd0;
	localparam logic [XLEN-2:0] C_ILLEGAL      = 31'd2;
	localparam logic [XLEN-2:0] C_BREAKPOINT   = 31'd3;
	localparam logic [XLEN-2:0] C_U_CALL       = 31'd8;  // plus mode for S and M

	// interrupt causes
	localparam logic [XLEN-2:0] C_U_TIMER = 31'd4;
	localparam logic [XLEN-2:0] C_S_TIMER = 31'd5;
	localparam logic [XLEN-2:0] C_M_TIMER = 31'd7;
	localparam logic [XLEN-2:0] C_U_EXT   = 31'd8;
	localparam logic [XLEN-2:0] C_S_EXT   = 31'd9;
	localparam logic [XLEN-2:0] C_M_EXT   = 31'd11;

	// result entry, low to high: exc, we, rd, pc, data
	localparam int EXC_LSB  = 0;
	localparam int WE_BIT   = EXC_LSB + EXC_W;
	localparam int RD_LSB   = WE_BIT + 1;
	localparam int PC_LSB   = RD_LSB + REG_ADDR_W;
	localparam int DATA_LSB = PC_LSB + XLEN;
	localparam int ENTRY_W  = DATA_LSB + XLEN;

	// mcause style word
	typedef union packed {
		logic [XLEN-1:0] raw;
		struct packed {
			logic            intr;
			logic [XLEN-2:0] code;
		} f;
	} trap_cause_u;

endpackage

// ==== verilog/exe_issue.sv ====
`timescale 1ns/10ps

module exe_issue #(
	parameter int DEPTH = 4
) (
	input  logic                                clk,
	input  logic                                nrst,
	input  logic                                issue_valid,
	output logic                                issue_ready,
	input  logic [exe_pkg::XLEN-1:0]            op_a,
	input  logic [exe_pkg::XLEN-1:0]            op_b,
	input  logic [exe_pkg::XLEN-1:0]            imm,
	input  logic [exe_pkg::XLEN-1:0]            pc,
	input  logic [exe_pkg::REG_ADDR_W-1:0]      rd,
	input  logic                                we,
	input  logic [exe_pkg::ALU_FN_W-1:0]        alu_fn,
	input  logic [exe_pkg::WB_SEL_W-1:0]        wb_sel,
	input  logic [exe_pkg::EXC_W-1:0]           exc,
	input  logic                                credit_return,
	input  logic                                flush,
	output logic                                push,
	output logic [exe_pkg::ENTRY_W-1:0]         push_entry
);

	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] credits;
	logic accept;
	logic valid_q;

	logic [exe_pkg::XLEN-1:0]       op_a_q, op_b_q, imm_q, pc_q;
	logic [exe_pkg::REG_ADDR_W-1:0] rd_q;
	logic                           we_q;
	logic [exe_pkg::ALU_FN_W-1:0]   alu_fn_q;
	logic [exe_pkg::WB_SEL_W-1:0]   wb_sel_q;
	logic [exe_pkg::EXC_W-1:0]      exc_q;

	logic [exe_pkg::XLEN-1:0] alu_res;
	logic [exe_pkg::XLEN-1:0] wb_data;

	assign issue_ready = (credits != '0);
	assign accept      = issue_valid && issue_ready;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			credits <= CNT_W'(DEPTH);
		else if (flush)
			credits <= CNT_W'(DEPTH); // everything outstanding is gone
		else if (accept && !credit_return)
			credits <= credits - 1'b1;
		else if (!accept && credit_return)
			credits <= credits + 1'b1;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			valid_q <= 1'b0;
		else
			valid_q <= accept && !flush; // an op taken on the flush edge is younger too
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_a_q   <= op_a;
			op_b_q   <= op_b;
			imm_q    <= imm;
			pc_q     <= pc;
			rd_q     <= rd;
			we_q     <= we;
			alu_fn_q <= alu_fn;
			wb_sel_q <= wb_sel;
			exc_q    <= exc;
		end
	end

	always_comb
	begin
		unique case (alu_fn_q)
			exe_pkg::ALU_ADD: alu_res = op_a_q + op_b_q;
			exe_pkg::ALU_SUB: alu_res = op_a_q - op_b_q;
			exe_pkg::ALU_AND: alu_res = op_a_q & op_b_q;
			exe_pkg::ALU_OR:  alu_res = op_a_q | op_b_q;
			exe_pkg::ALU_XOR: alu_res = op_a_q ^ op_b_q;
			exe_pkg::ALU_SLL: alu_res = op_a_q << op_b_q[4:0];
			exe_pkg::ALU_SRL: alu_res = op_a_q >> op_b_q[4:0];
			exe_pkg::ALU_SLT: alu_res = {{(exe_pkg::XLEN-1){1'b0}},
				($signed(op_a_q) < $signed(op_b_q))};
			default: alu_res = '0;
		endcase
	end

	always_comb
	begin
		unique case (wb_sel_q)
			exe_pkg::WB_ALU:   wb_data = alu_res;
			exe_pkg::WB_PC4:   wb_data = pc_q + 32'd4;  // link address
			exe_pkg::WB_LUI:   wb_data = imm_q;
			exe_pkg::WB_AUIPC: wb_data = pc_q + imm_q;
			default:           wb_data = '0;
		endcase
	end

	assign push       = valid_q;
	assign push_entry = {wb_data, pc_q, rd_q, we_q, exc_q};

	// credits only come back for entries that were paid for
	a_credit_bound: assert property (@(posedge clk) disable iff (!nrst)
		credits <= CNT_W'(DEPTH));

endmodule

// ==== verilog/result_fifo.sv ====
`timescale 1ns/10ps

module result_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        nrst,
	input  logic                        push,
	input  logic [exe_pkg::ENTRY_W-1:0] push_entry,
	input  logic                        pop,
	input  logic                        flush,
	output logic [exe_pkg::ENTRY_W-1:0] head_entry,
	output logic                        not_empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

	logic [exe_pkg::ENTRY_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign full       = (count == CNT_W'(DEPTH));
	assign not_empty  = (count != '0);
	assign head_entry = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else if (flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// producer credits must keep these from ever firing
	a_no_overflow: assert property (@(posedge clk) disable iff (!nrst) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!nrst) pop |-> not_empty);

endmodule

// ==== verilog/exe_commit.sv ====
`timescale 1ns/10ps

module exe_commit (
	input  logic                           clk,
	input  logic                           nrst,
	input  logic [exe_pkg::ENTRY_W-1:0]    head_entry,
	input  logic                           not_empty,
	output logic                           pop,
	input  logic                           out_ready,
	output logic                           credit_return,
	output logic                           flush,
	input  logic [exe_pkg::MODE_W-1:0]     current_mode,
	input  logic                           m_tie,
	input  logic                           s_tie,
	input  logic                           u_tie,
	input  logic                           m_eie,
	input  logic                           s_eie,
	input  logic                           u_eie,
	input  logic                           m_timer,
	input  logic                           s_timer,
	input  logic                           u_timer,
	input  logic                           ext_irq,
	output logic                           commit_valid,
	output logic [exe_pkg::REG_ADDR_W-1:0] commit_rd,
	output logic                           commit_we,
	output logic [exe_pkg::XLEN-1:0]       commit_data,
	output logic [exe_pkg::XLEN-1:0]       commit_pc,
	output logic                           trap,
	output logic [exe_pkg::XLEN-1:0]       trap_cause
);

	logic [exe_pkg::XLEN-1:0]       head_data;
	logic [exe_pkg::XLEN-1:0]       head_pc;
	logic [exe_pkg::REG_ADDR_W-1:0] head_rd;
	logic                           head_we;
	logic [exe_pkg::EXC_W-1:0]      head_exc;

	logic m_ext_c, s_ext_c, u_ext_c;
	logic m_tmr_c, s_tmr_c, u_tmr_c;
	logic irq_any;
	logic trap_n;
	exe_pkg::trap_cause_u cause_n;

	assign head_data = head_entry[exe_pkg::DATA_LSB +: exe_pkg::XLEN];
	assign head_pc   = head_entry[exe_pkg::PC_LSB +: exe_pkg::XLEN];
	assign head_rd   = head_entry[exe_pkg::RD_LSB +: exe_pkg::REG_ADDR_W];
	assign head_we   = head_entry[exe_pkg::WE_BIT];
	assign head_exc  = head_entry[exe_pkg::EXC_LSB +: exe_pkg::EXC_W];

	// S level is masked in M mode, U level outside U mode
	assign m_ext_c = m_eie && ext_irq;
	assign s_ext_c = (current_mode != exe_pkg::MODE_M) && s_eie && ext_irq;
	assign u_ext_c = (current_mode == exe_pkg::MODE_U) && u_eie && ext_irq;
	assign m_tmr_c = m_tie && m_timer;
	assign s_tmr_c = (current_mode != exe_pkg::MODE_M) && s_tie && s_timer;
	assign u_tmr_c = (current_mode == exe_pkg::MODE_U) && u_tie && u_timer;

	assign irq_any = m_ext_c || s_ext_c || m_tmr_c || s_tmr_c || u_ext_c || u_tmr_c;
	assign trap_n  = irq_any || (head_exc != '0);

	always_comb
	begin
		cause_n.raw = '0;
		cause_n.f.intr = irq_any;
		if (m_ext_c)
			cause_n.f.code = exe_pkg::C_M_EXT;
		else if (s_ext_c)
			cause_n.f.code = exe_pkg::C_S_EXT;
		else if (m_tmr_c)
			cause_n.f.code = exe_pkg::C_M_TIMER;
		else if (s_tmr_c)
			cause_n.f.code = exe_pkg::C_S_TIMER;
		else if (u_ext_c)
			cause_n.f.code = exe_pkg::C_U_EXT;
		else if (u_tmr_c)
			cause_n.f.code = exe_pkg::C_U_TIMER;
		else if (head_exc[exe_pkg::EXC_MISALIGNED])
			cause_n.f.code = exe_pkg::C_I_MISALIGNED;
		else if (head_exc[exe_pkg::EXC_ILLEGAL])
			cause_n.f.code = exe_pkg::C_ILLEGAL;
		else if (head_exc[exe_pkg::EXC_ECALL])
			cause_n.f.code = exe_pkg::C_U_CALL + {{(exe_pkg::XLEN-1-exe_pkg::MODE_W){1'b0}},
				current_mode};
		else if (head_exc[exe_pkg::EXC_EBREAK])
			cause_n.f.code = exe_pkg::C_BREAKPOINT;
	end

	assign pop           = not_empty && out_ready;
	assign credit_return = pop;           // one credit per popped entry
	assign flush         = pop && trap_n; // drop all younger work

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			commit_valid <= 1'b0;
			commit_we    <= 1'b0;
			trap         <= 1'b0;
			trap_cause   <= '0;
		end
		else
		begin
			commit_valid <= pop;
			commit_we    <= pop && head_we && !trap_n; // trapped entry never writes
			trap         <= pop && trap_n;
			trap_cause   <= pop ? cause_n.raw : '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			commit_rd   <= head_rd;
			commit_data <= head_data;
			commit_pc   <= head_pc;
		end
	end

	a_cause_with_trap: assert property (@(posedge clk) disable iff (!nrst)
		(trap_cause != '0) |-> trap);

endmodule

// ==== verilog/exe_stage_top.sv ====
`timescale 1ns/10ps

module exe_stage_top #(
	parameter int DEPTH = 4
) (
	input  logic                           clk,
	input  logic                           nrst,
	input  logic                           issue_valid,
	output logic                           issue_ready,
	input  logic [exe_pkg::XLEN-1:0]       op_a,
	input  logic [exe_pkg::XLEN-1:0]       op_b,
	input  logic [exe_pkg::XLEN-1:0]       imm,
	input  logic [exe_pkg::XLEN-1:0]       pc,
	input  logic [exe_pkg::REG_ADDR_W-1:0] rd,
	input  logic                           we,
	input  logic [exe_pkg::ALU_FN_W-1:0]   alu_fn,
	input  logic [exe_pkg::WB_SEL_W-1:0]   wb_sel,
	input  logic [exe_pkg::EXC_W-1:0]      exc,
	input  logic [exe_pkg::MODE_W-1:0]     current_mode,
	input  logic                           m_tie,
	input  logic                           s_tie,
	input  logic                           u_tie,
	input  logic                           m_eie,
	input  logic                           s_eie,
	input  logic                           u_eie,
	input  logic                           m_timer,
	input  logic                           s_timer,
	input  logic                           u_timer,
	input  logic                           ext_irq,
	input  logic                           out_ready,
	output logic                           commit_valid,
	output logic [exe_pkg::REG_ADDR_W-1:0] commit_rd,
	output logic                           commit_we,
	output logic [exe_pkg::XLEN-1:0]       commit_data,
	output logic [exe_pkg::XLEN-1:0]       commit_pc,
	output logic                           trap,
	output logic [exe_pkg::XLEN-1:0]       trap_cause
);

	logic                        push;
	logic [exe_pkg::ENTRY_W-1:0] push_entry;
	logic [exe_pkg::ENTRY_W-1:0] head_entry;
	logic                        not_empty;
	logic                        pop;
	logic                        credit_return;
	logic                        flush;

	exe_issue #(.DEPTH(DEPTH)) i_exe_issue (
		.clk, .nrst, .issue_valid, .issue_ready,
		.op_a, .op_b, .imm, .pc, .rd, .we, .alu_fn, .wb_sel, .exc,
		.credit_return, .flush, .push, .push_entry
	);

	result_fifo #(.DEPTH(DEPTH)) i_result_fifo (
		.clk, .nrst, .push, .push_entry, .pop, .flush, .head_entry, .not_empty
	);

	exe_commit i_exe_commit (
		.clk, .nrst, .head_entry, .not_empty, .pop, .out_ready, .credit_return, .flush,
		.current_mode, .m_tie, .s_tie, .u_tie, .m_eie, .s_eie, .u_eie,
		.m_timer, .s_timer, .u_timer, .ext_irq,
		.commit_valid, .commit_rd, .commit_we, .commit_data, .commit_pc,
		.trap, .trap_cause
	);

endmodule

// ==== bench/exe_tb.sv ====
`timescale 1ns/10ps

module exe_tb;

	localparam int DEPTH = 4;
	localparam string TEST_FILE = "bench/exe_tests.txt";

	logic                           clk;
	logic                           nrst;
	logic                           issue_valid;
	logic                           issue_ready;
	logic [exe_pkg::XLEN-1:0]       op_a;
	logic [exe_pkg::XLEN-1:0]       op_b;
	logic [exe_pkg::XLEN-1:0]       imm;
	logic [exe_pkg::XLEN-1:0]       pc;
	logic [exe_pkg::REG_ADDR_W-1:0] rd;
	logic                           we;
	logic [exe_pkg::ALU_FN_W-1:0]   alu_fn;
	logic [exe_pkg::WB_SEL_W-1:0]   wb_sel;
	logic [exe_pkg::EXC_W-1:0]      exc;
	logic [exe_pkg::MODE_W-1:0]     current_mode;
	logic                           m_tie, s_tie, u_tie;
	logic                           m_eie, s_eie, u_eie;
	logic                           m_timer, s_timer, u_timer;
	logic                           ext_irq;
	logic                           out_ready;
	logic                           commit_valid;
	logic [exe_pkg::REG_ADDR_W-1:0] commit_rd;
	logic                           commit_we;
	logic [exe_pkg::XLEN-1:0]       commit_data;
	logic [exe_pkg::XLEN-1:0]       commit_pc;
	logic                           trap;
	logic [exe_pkg::XLEN-1:0]       trap_cause;

	// expected commits with the oldest at the front
	logic [exe_pkg::XLEN-1:0]       exp_data_q[$];
	logic [exe_pkg::XLEN-1:0]       exp_pc_q[$];
	logic [exe_pkg::REG_ADDR_W-1:0] exp_rd_q[$];
	logic                           exp_we_q[$];
	logic                           exp_trap_q[$];
	exe_pkg::trap_cause_u           exp_cause_q[$];

	int issued;
	int committed;
	int cycles;
	int cycle_limit;   // 0 until the test file is counted
	int hold_cycles;
	bit saw_not_ready;

	exe_stage_top #(.DEPTH(DEPTH)) i_exe_stage_top (.*);

	always #20 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_data(input string name, input logic [exe_pkg::XLEN-1:0] expected,
		input logic [exe_pkg::XLEN-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0t: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_rd(input logic [exe_pkg::REG_ADDR_W-1:0] expected,
		input logic [exe_pkg::REG_ADDR_W-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0t: commit_rd expected %0d, got %0d",
				$time, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0t: %s expected %b, got %b",
				$time, name, expected, actual));
	endtask

	task automatic check_cause(input exe_pkg::trap_cause_u expected,
		input exe_pkg::trap_cause_u actual);
		if (actual.raw !== expected.raw)
			abort_run($sformatf("FAIL at %0t: trap_cause expected %h, got %h",
				$time, expected.raw, actual.raw));
	endtask

	// returns at a rising edge plus 1 ns
	task automatic wait_drain();
		while (committed != issued)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic issue_op(
		input logic [exe_pkg::XLEN-1:0]       a_val,
		input logic [exe_pkg::XLEN-1:0]       b_val,
		input logic [exe_pkg::XLEN-1:0]       imm_val,
		input logic [exe_pkg::XLEN-1:0]       pc_val,
		input logic [exe_pkg::REG_ADDR_W-1:0] rd_val,
		input logic                           we_val,
		input logic [exe_pkg::ALU_FN_W-1:0]   fn_val,
		input logic [exe_pkg::WB_SEL_W-1:0]   sel_val,
		input logic [exe_pkg::EXC_W-1:0]      exc_val
	);
		issue_valid = 1'b1;
		op_a = a_val;
		op_b = b_val;
		imm = imm_val;
		pc = pc_val;
		rd = rd_val;
		we = we_val;
		alu_fn = fn_val;
		wb_sel = sel_val;
		exc = exc_val;
		while (!issue_ready) // credits only change on edges
		begin
			if (issued - committed < DEPTH)
				abort_run($sformatf("issue_ready fell with only %0d operations outstanding",
					issued - committed));
			saw_not_ready = 1'b1;
			@(posedge clk);
			#1;
		end
		@(posedge clk); // transfer edge
		#1;
		issue_valid = 1'b0;
		issued = issued + 1;
	endtask

	// out_ready is random or held low
	initial
	begin
		void'($urandom(72));
		forever
		begin
			@(posedge clk);
			if (hold_cycles > 0)
			begin
				hold_cycles = hold_cycles - 1;
				#1 out_ready = 1'b0;
			end
			else
				#1 out_ready = (($urandom % 100) < 70);
		end
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			abort_run($sformatf("timeout after %0d cycles with %0d of %0d operations committed",
				cycles, committed, issued));
	end

	// commit monitor samples mid cycle
	always @(negedge clk)
	begin
		exe_pkg::trap_cause_u got_cause;
		if (nrst && commit_valid)
		begin
			if (exp_data_q.size() == 0)
				abort_run("a commit arrived while no operation was waiting to commit");
			else
			begin
				got_cause.raw = trap_cause;
				check_data("commit_data", exp_data_q.pop_front(), commit_data);
				check_data("commit_pc", exp_pc_q.pop_front(), commit_pc);
				check_rd(exp_rd_q.pop_front(), commit_rd);
				check_bit("commit_we", exp_we_q.pop_front(), commit_we);
				check_bit("trap", exp_trap_q.pop_front(), trap);
				check_cause(exp_cause_q.pop_front(), got_cause);
				committed = committed + 1;
			end
		end
		else if (nrst)
			check_bit("trap", 1'b0, trap); // idle cycle
	end

	initial
	begin
		int fd;
		int n;
		int n_lines;
		string line;
		logic [7:0] kind;
		logic [31:0] f [13];
		int hold_val;
		exe_pkg::trap_cause_u cause;

		clk = 1'b0;
		nrst = 1'b0;
		issue_valid = 1'b0;
		op_a = '0;
		op_b = '0;
		imm = '0;
		pc = '0;
		rd = '0;
		we = 1'b0;
		alu_fn = '0;
		wb_sel = '0;
		exc = '0;
		current_mode = exe_pkg::MODE_M;
		{m_tie, s_tie, u_tie, m_eie, s_eie, u_eie} = '0;
		{m_timer, s_timer, u_timer, ext_irq} = '0;
		out_ready = 1'b0;
		issued = 0;
		committed = 0;
		cycles = 0;
		cycle_limit = 0;
		hold_cycles = 0;
		saw_not_ready = 1'b0;

		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			abort_run($sformatf("could not open %s", TEST_FILE));
		n_lines = 0;
		while ($fgets(line, fd) != 0)
			n_lines = n_lines + 1;
		$fclose(fd);
		cycle_limit = 50 * n_lines + 100;

		repeat (10) @(posedge clk);
		#1 nrst = 1'b1;

		fd = $fopen(TEST_FILE, "r");
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			kind = line.getc(0);
			case (kind)
				"s":
				begin
					n = $sscanf(line, "s %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
					if (n != 11)
						abort_run($sformatf("unreadable state line: %s", line));
					wait_drain(); // levels apply to whatever pops next
					current_mode = f[0][exe_pkg::MODE_W-1:0];
					m_tie = f[1][0];
					s_tie = f[2][0];
					u_tie = f[3][0];
					m_eie = f[4][0];
					s_eie = f[5][0];
					u_eie = f[6][0];
					m_timer = f[7][0];
					s_timer = f[8][0];
					u_timer = f[9][0];
					ext_irq = f[10][0];
				end
				"h":
				begin
					n = $sscanf(line, "h %d", hold_val);
					if (n != 1)
						abort_run($sformatf("unreadable hold line: %s", line));
					hold_cycles = hold_val;
				end
				"i":
				begin
					n = $sscanf(line, "i %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12]);
					if (n != 13)
						abort_run($sformatf("unreadable issue line: %s", line));
					exp_data_q.push_back(f[9]);
					exp_pc_q.push_back(f[3]);
					exp_rd_q.push_back(f[4][exe_pkg::REG_ADDR_W-1:0]);
					exp_we_q.push_back(f[10][0]);
					exp_trap_q.push_back(f[11][0]);
					cause.raw = f[12];
					exp_cause_q.push_back(cause);
					issue_op(f[0], f[1], f[2], f[3], f[4][exe_pkg::REG_ADDR_W-1:0], f[5][0],
						f[6][exe_pkg::ALU_FN_W-1:0], f[7][exe_pkg::WB_SEL_W-1:0],
						f[8][exe_pkg::EXC_W-1:0]);
					if (f[11][0])
						wait_drain(); // nothing younger may sit behind a trap
				end
				default:
					abort_run($sformatf("unknown line kind in %s: %s", TEST_FILE, line));
			endcase
		end
		$fclose(fd);
		wait_drain();

		if (committed == issued && exp_data_q.size() == 0 && saw_not_ready)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
			abort_run($sformatf("run ended with %0d of %0d committed, issue_ready low seen %0b",
				committed, issued, saw_not_ready));
	end

endmodule

// ==== sources.f ====
verilog/exe_pkg.sv
verilog/exe_issue.sv
verilog/result_fifo.sv
verilog/exe_commit.sv
verilog/exe_stage_top.sv
bench/exe_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = exe_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/exe_tests.txt ====
# s: mode m_tie s_tie u_tie m_eie s_eie u_eie m_timer s_timer u_timer ext_irq (hex)
# h: cycles with out_ready held low (decimal)
# i: op_a op_b imm pc rd we alu_fn wb_sel exc exp_data exp_we exp_trap exp_cause (hex)
s 3 0 0 0 0 0 0 0 0 0 0
i 00000005 00000003 00000000 00001000 01 1 0 0 0 00000008 1 0 00000000
i 00000003 00000005 00000000 00001004 02 1 1 0 0 fffffffe 1 0 00000000
i f0f0f0f0 ff00ff00 00000000 00001008 03 1 2 0 0 f000f000 1 0 00000000
i f0f0f0f0 0f0f0000 00000000 0000100c 04 1 3 0 0 fffff0f0 1 0 00000000
i aaaa5555 ffff0000 00000000 00001010 05 1 4 0 0 55555555 1 0 00000000
i 00000001 00000024 00000000 00001014 06 1 5 0 0 00000010 1 0 00000000
i 80000000 0000003f 00000000 00001018 07 1 6 0 0 00000001 1 0 00000000
i ffffffff 00000001 00000000 0000101c 08 1 7 0 0 00000001 1 0 00000000
i 00000001 ffffffff 00000000 00001020 09 1 7 0 0 00000000 1 0 00000000
i 00000000 00000000 00000000 00001024 0a 1 0 1 0 00001028 1 0 00000000
i 00000000 00000000 12345000 00001028 0b 1 0 2 0 12345000 1 0 00000000
i 00000000 00000000 fffff000 00002000 0c 1 0 3 0 00001000 1 0 00000000
i 00000007 00000001 00000000 00002004 0d 0 0 0 0 00000008 0 0 00000000
h 12
i 00000001 00000001 00000000 00003000 10 1 0 0 0 00000002 1 0 00000000
i 00000002 00000002 00000000 00003004 11 1 0 0 0 00000004 1 0 00000000
i 00000003 00000003 00000000 00003008 12 1 0 0 0 00000006 1 0 00000000
i 00000004 00000004 00000000 0000300c 13 1 0 0 0 00000008 1 0 00000000
i 00000005 00000005 00000000 00003010 14 1 0 0 0 0000000a 1 0 00000000
i 00000006 00000006 00000000 00003014 15 1 0 0 0 0000000c 1 0 00000000
i 00000001 00000002 00000000 00004000 05 1 0 0 8 00000003 0 1 00000000
i 00000001 00000002 00000000 00004004 05 1 0 0 4 00000003 0 1 00000002
i 00000001 00000002 00000000 00004008 05 1 0 0 2 00000003 0 1 0000000b
i 00000001 00000002 00000000 0000400c 05 1 0 0 1 00000003 0 1 00000003
i 00000001 00000002 00000000 00004010 05 1 0 0 f 00000003 0 1 00000000
i 00000001 00000002 00000000 00004014 05 1 0 0 6 00000003 0 1 00000002
i 00000001 00000002 00000000 00004018 05 1 0 0 3 00000003 0 1 0000000b
i 00000009 00000001 00000000 0000401c 06 1 1 0 0 00000008 1 0 00000000
s 0 0 0 0 0 0 0 0 0 0 0
i 00000001 00000002 00000000 00004020 05 1 0 0 2 00000003 0 1 00000008
s 1 0 0 0 0 0 0 0 0 0 0
i 00000001 00000002 00000000 00004024 05 1 0 0 2 00000003 0 1 00000009
s 3 0 0 0 1 0 0 0 0 0 1
i 00000001 00000002 00000000 00005000 05 1 0 0 4 00000003 0 1 8000000b
s 3 0 0 0 0 1 0 0 0 0 1
i 00000001 00000002 00000000 00005004 05 1 0 0 0 00000003 1 0 00000000
s 1 1 0 0 0 1 0 1 0 0 1
i 00000001 00000002 00000000 00005008 05 1 0 0 0 00000003 0 1 80000009
s 1 1 1 0 0 0 0 1 1 0 0
i 00000001 00000002 00000000 0000500c 05 1 0 0 0 00000003 0 1 80000007
s 0 0 1 1 0 0 1 0 1 1 1
i 00000001 00000002 00000000 00005010 05 1 0 0 0 00000003 0 1 80000005
s 0 0 0 1 0 0 1 0 0 1 1
i 00000001 00000002 00000000 00005014 05 1 0 0 0 00000003 0 1 80000008
s 0 0 0 1 0 0 0 0 0 1 0
i 00000001 00000002 00000000 00005018 05 1 0 0 0 00000003 0 1 80000004
s 1 0 0 1 0 0 1 0 0 1 1
i 00000001 00000002 00000000 0000501c 05 1 0 0 0 00000003 1 0 00000000
s 0 0 0 0 0 0 0 1 1 1 1
i 00000001 00000002 00000000 00005020 05 1 0 0 0 00000003 1 0 00000000
s 3 0 0 0 0 0 0 0 0 0 0
i 0000000a 00000004 00000000 00006000 1f 1 1 0 0 00000006 1 0 00000000
i 00000000 00000000 00000000 00006004 1e 1 0 1 0 00006008 1 0 00000000
